/* source/fetch_pkg.sv */
// Shared types and constants for the dual-hart fetch subsystem
package fetch_pkg;

    // Number of harts sharing the instruction ROM
    localparam int NUM_HARTS = 2;

    // ROM geometry; the index wraps within ROM_WORDS
    localparam int ROM_WORDS = 32;

    // Hex image loaded into the ROM at time zero
    localparam string ROM_FILE = "program.hex";

    // Entries per hart in the fetch queue
    localparam int QUEUE_DEPTH = 4;

    // Credits held by a fetch unit right after reset
    localparam int CREDITS_INIT = 4;

    // Byte program counter, same width as the ROM address
    typedef logic [15:0] pc_t;

    // One RV32 instruction word
    typedef logic [31:0] instr_t;

    // Word index into the ROM
    typedef logic [4:0] rom_idx_t;

    // Credit count, wide enough for CREDITS_INIT
    typedef logic [2:0] credit_t;

    // Fetch starts here on both harts
    localparam pc_t RESET_PC = 16'h0000;

    // Which hart won the ROM last; the other one has priority next
    typedef enum logic {
        LAST_H0,
        LAST_H1
    } arb_state_t;

endpackage

/* source/instr_rom.sv */
`timescale 1ns/1ps

// Read-only instruction memory, word organised, byte addressed
module instr_rom (
    input  fetch_pkg::pc_t    addr,
    output fetch_pkg::instr_t rd
);
    import fetch_pkg::*;

    // Word storage, no write port
    instr_t rom [ROM_WORDS];

    // Word index taken from the byte address
    rom_idx_t idx;

    // Program image comes from the hex file
    initial begin
        $readmemh(ROM_FILE, rom);
    end

    // Drop the byte offset, then keep only the index bits
    // so fetches past the end wrap back to word 0
    assign idx = rom_idx_t'(addr >> 2);

    // Purely combinational read
    assign rd = rom[idx];

endmodule

/* source/rom_arbiter.sv */
`timescale 1ns/1ps

// Round-robin arbiter for the single ROM read port
module rom_arbiter (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [fetch_pkg::NUM_HARTS-1:0] req,
    input  fetch_pkg::pc_t                  addr_h0,
    input  fetch_pkg::pc_t                  addr_h1,
    output logic [fetch_pkg::NUM_HARTS-1:0] grant,
    output fetch_pkg::pc_t                  rom_addr
);
    import fetch_pkg::*;

    // Hart that got the ROM most recently
    arb_state_t last_q;

    // Grant is combinational from the requests
    always_comb begin
        grant = '0;
        if (req[0] && req[1]) begin
            // Conflict goes to whoever did not win last time
            if (last_q == LAST_H0) begin
                grant[1] = 1'b1;
            end else begin
                grant[0] = 1'b1;
            end
        end else begin
            // A lone requester always wins
            grant = req;
        end
    end

    // Winner's address drives the ROM
    assign rom_addr = grant[1] ? addr_h1 : addr_h0;

    // Remember the winner to rotate priority
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Hart 0 gets first pick after reset
            last_q <= LAST_H1;
        end else if (grant[0]) begin
            last_q <= LAST_H0;
        end else if (grant[1]) begin
            last_q <= LAST_H1;
        end
    end

endmodule

/* source/fetch_queue.sv */
`timescale 1ns/1ps

// Small circular buffer of fetched instruction and pc pairs
module fetch_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              push,
    input  fetch_pkg::instr_t push_instr,
    input  fetch_pkg::pc_t    push_pc,
    input  logic              pop,
    output fetch_pkg::instr_t head_instr,
    output fetch_pkg::pc_t    head_pc,
    output logic              empty,
    output logic              room
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Entry storage
    instr_t instr_mem [QUEUE_DEPTH];
    pc_t    pc_mem    [QUEUE_DEPTH];

    // Pointers and occupancy
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Qualified push and pop, both dropped on flush
    logic do_push;
    logic do_pop;

    assign empty = (count == '0);

    // A pop this cycle frees a slot for a push this cycle
    assign room = (count < CNT_W'(QUEUE_DEPTH)) || pop;

    assign do_push = push && !flush;
    assign do_pop  = pop && !empty && !flush;

    // Head is read combinationally
    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    // Payload write
    always_ff @(posedge clk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

    // Pointer and count update
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // Explicit wrap, depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

// Per-hart fetch: pc, ROM request, queue and credit-based delivery
module fetch_unit (
    input  logic              clk,
    input  logic              rst_n,
    output logic              rom_req,
    output fetch_pkg::pc_t    rom_addr,
    input  logic              grant,
    input  fetch_pkg::instr_t rom_rd,
    input  logic              redirect_valid,
    input  fetch_pkg::pc_t    redirect_pc,
    input  logic              credit_return,
    output logic              instr_valid,
    output fetch_pkg::instr_t instr,
    output fetch_pkg::pc_t    instr_pc
);
    import fetch_pkg::*;

    // Address of the next word to fetch
    pc_t pc_q;

    // Decoder slots still free
    credit_t credit_q;

    // Low during reset and the cycle after it
    logic active_q;

    // Queue handshake
    logic q_push;
    logic q_pop;
    logic q_empty;
    logic q_room;

    // Ask for the ROM whenever the queue can take one more word
    assign rom_req  = active_q && q_room;
    assign rom_addr = pc_q;

    // Granted word is accepted unless a redirect throws it away
    assign q_push = grant && !redirect_valid;

    // Deliver the head when there is one, a credit, and no redirect
    assign q_pop = !q_empty && (credit_q != '0) && !redirect_valid;

    // Delivery is a one-cycle pulse per popped entry
    assign instr_valid = q_pop;

    fetch_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect_valid),
        .push       (q_push),
        .push_instr (rom_rd),
        .push_pc    (pc_q),
        .pop        (q_pop),
        .head_instr (instr),
        .head_pc    (instr_pc),
        .empty      (q_empty),
        .room       (q_room)
    );

    // Request enable comes up one cycle after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    // Program counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid) begin
            // Target is forced to a word boundary
            pc_q <= {redirect_pc[15:2], 2'b00};
        end else if (q_push) begin
            pc_q <= pc_q + 16'd4;
        end
    end

    // Credit counter, kept across redirects
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_q <= credit_t'(CREDITS_INIT);
        end else begin
            case ({q_pop, credit_return})
                2'b10: begin
                    credit_q <= credit_q - 1'b1;
                end
                2'b01: begin
                    credit_q <= credit_q + 1'b1;
                end
                // Spend and return in one cycle cancel out
                default: begin
                    credit_q <= credit_q;
                end
            endcase
        end
    end

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ps

// Two fetch units sharing one instruction ROM
module fetch_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              redirect_valid_h0,
    input  fetch_pkg::pc_t    redirect_pc_h0,
    input  logic              credit_return_h0,
    output logic              instr_valid_h0,
    output fetch_pkg::instr_t instr_h0,
    output fetch_pkg::pc_t    instr_pc_h0,
    input  logic              redirect_valid_h1,
    input  fetch_pkg::pc_t    redirect_pc_h1,
    input  logic              credit_return_h1,
    output logic              instr_valid_h1,
    output fetch_pkg::instr_t instr_h1,
    output fetch_pkg::pc_t    instr_pc_h1
);
    import fetch_pkg::*;

    // Request and grant, one bit per hart
    logic [NUM_HARTS-1:0] rom_req;
    logic [NUM_HARTS-1:0] rom_grant;

    // Per-hart fetch addresses and the arbitrated ROM port
    pc_t    fetch_addr_h0;
    pc_t    fetch_addr_h1;
    pc_t    rom_addr;
    instr_t rom_rd;

    // Hart 0
    fetch_unit u_fetch_h0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .rom_req        (rom_req[0]),
        .rom_addr       (fetch_addr_h0),
        .grant          (rom_grant[0]),
        .rom_rd         (rom_rd),
        .redirect_valid (redirect_valid_h0),
        .redirect_pc    (redirect_pc_h0),
        .credit_return  (credit_return_h0),
        .instr_valid    (instr_valid_h0),
        .instr          (instr_h0),
        .instr_pc       (instr_pc_h0)
    );

    // Hart 1
    fetch_unit u_fetch_h1 (
        .clk            (clk),
        .rst_n          (rst_n),
        .rom_req        (rom_req[1]),
        .rom_addr       (fetch_addr_h1),
        .grant          (rom_grant[1]),
        .rom_rd         (rom_rd),
        .redirect_valid (redirect_valid_h1),
        .redirect_pc    (redirect_pc_h1),
        .credit_return  (credit_return_h1),
        .instr_valid    (instr_valid_h1),
        .instr          (instr_h1),
        .instr_pc       (instr_pc_h1)
    );

    rom_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (rom_req),
        .addr_h0  (fetch_addr_h0),
        .addr_h1  (fetch_addr_h1),
        .grant    (rom_grant),
        .rom_addr (rom_addr)
    );

    // Read data goes to both harts, only the granted one keeps it
    instr_rom u_rom (
        .addr (rom_addr),
        .rd   (rom_rd)
    );

endmodule

/* bench/tb_checker.sv */
`timescale 1ns/1ps

// Watches both fetch ports and compares them with a reference model
module tb_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              hold_credits,
    input logic              redirect_valid_h0,
    input fetch_pkg::pc_t    redirect_pc_h0,
    input logic              credit_return_h0,
    input logic              instr_valid_h0,
    input fetch_pkg::instr_t instr_h0,
    input fetch_pkg::pc_t    instr_pc_h0,
    input logic              redirect_valid_h1,
    input fetch_pkg::pc_t    redirect_pc_h1,
    input logic              credit_return_h1,
    input logic              instr_valid_h1,
    input fetch_pkg::instr_t instr_h1,
    input fetch_pkg::pc_t    instr_pc_h1
);
    import fetch_pkg::*;

    // Longest gap between deliveries while both harts have credit
    localparam int STALL_LIMIT = 16;

    // Reference copy of the program image
    instr_t model [ROM_WORDS];

    // Port views indexed by hart
    logic   rv  [NUM_HARTS];
    pc_t    rpc [NUM_HARTS];
    logic   cr  [NUM_HARTS];
    logic   iv  [NUM_HARTS];
    instr_t iw  [NUM_HARTS];
    pc_t    ipc [NUM_HARTS];

    // Per-hart model state
    pc_t  exp_pc     [NUM_HARTS];
    int   credits    [NUM_HARTS];
    int   stall      [NUM_HARTS];
    int   win_exp    [NUM_HARTS];
    int   win_cnt    [NUM_HARTS];
    logic first_done [NUM_HARTS];
    logic hold_q    = 1'b0;

    // Rising edges seen since reset was released, saturates at 2
    int   up_cycles = 0;

    // Error counts read by the bench at the end
    int content_errs  = 0;
    int sequence_errs = 0;
    int redirect_errs = 0;
    int credit_errs   = 0;
    int progress_errs = 0;
    int reset_errs    = 0;

    initial begin
        $readmemh(ROM_FILE, model);
    end

    assign rv[0]  = redirect_valid_h0;
    assign rpc[0] = redirect_pc_h0;
    assign cr[0]  = credit_return_h0;
    assign iv[0]  = instr_valid_h0;
    assign iw[0]  = instr_h0;
    assign ipc[0] = instr_pc_h0;
    assign rv[1]  = redirect_valid_h1;
    assign rpc[1] = redirect_pc_h1;
    assign cr[1]  = credit_return_h1;
    assign iv[1]  = instr_valid_h1;
    assign iw[1]  = instr_h1;
    assign ipc[1] = instr_pc_h1;

    // Ports are sampled on the rising edge while they are stable
    always @(posedge clk) begin : check_cycle
        logic   both_credit;
        instr_t exp_word;
        both_credit = (credits[0] > 0) && (credits[1] > 0);
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (!rst_n) begin
                if (iv[h]) begin
                    reset_errs++;
                    $display("reset: hart %0d raised instr_valid during reset", h);
                end
                exp_pc[h]     = RESET_PC;
                credits[h]    = CREDITS_INIT;
                stall[h]      = 0;
                win_exp[h]    = 0;
                win_cnt[h]    = 0;
                first_done[h] = 1'b0;
            end else begin
                // Release edge and the first full cycle after it
                if (up_cycles < 2 && iv[h]) begin
                    reset_errs++;
                    $display("reset: hart %0d raised instr_valid in the first cycle after reset",
                             h);
                end
                // Every credit held at the start of a hold window is spent by its end
                if (hold_q && !hold_credits && win_cnt[h] != win_exp[h]) begin
                    credit_errs++;
                    $display("ERR credit_hold: hart %0d expected %0d actual %0d",
                             h, win_exp[h], win_cnt[h]);
                end
                if (hold_credits && !hold_q) begin
                    win_exp[h] = credits[h];
                    win_cnt[h] = 0;
                end
                if (rv[h]) begin
                    if (iv[h]) begin
                        redirect_errs++;
                        $display("redirect: hart %0d delivered while its redirect was high", h);
                    end
                    // Next delivery must come from the word-aligned target
                    exp_pc[h]     = rpc[h] & ~pc_t'(3);
                    first_done[h] = 1'b1;
                end else if (iv[h]) begin
                    if (ipc[h] != exp_pc[h]) begin
                        sequence_errs++;
                        $display("ERR %s: hart %0d expected %h actual %h",
                                 first_done[h] ? "sequence" : "reset_pc",
                                 h, exp_pc[h], ipc[h]);
                    end
                    // ROM index is the word address modulo the ROM size
                    exp_word = model[(int'(ipc[h]) >> 2) % ROM_WORDS];
                    if (iw[h] != exp_word) begin
                        content_errs++;
                        $display("ERR content: hart %0d expected %h actual %h",
                                 h, exp_word, iw[h]);
                    end
                    if (credits[h] == 0) begin
                        credit_errs++;
                        $display("credit: hart %0d delivered with no credit left", h);
                    end else begin
                        credits[h]--;
                    end
                    if (hold_credits) begin
                        win_cnt[h]++;
                    end
                    exp_pc[h]     = ipc[h] + 16'd4;
                    first_done[h] = 1'b1;
                end
                if (cr[h]) begin
                    if (credits[h] >= CREDITS_INIT) begin
                        credit_errs++;
                        $display("credit: hart %0d got a credit back with none outstanding", h);
                    end else begin
                        credits[h]++;
                    end
                end
                // Stall counter only runs while both harts could deliver
                if (both_credit && !(iv[h] && !rv[h])) begin
                    stall[h]++;
                end else begin
                    stall[h] = 0;
                end
                if (stall[h] >= STALL_LIMIT) begin
                    progress_errs++;
                    $display("progress: hart %0d delivered nothing for %0d cycles with credit",
                             h, STALL_LIMIT);
                    stall[h] = 0;
                end
            end
        end
        hold_q = rst_n && hold_credits;
        if (!rst_n) begin
            up_cycles = 0;
        end else if (up_cycles < 2) begin
            up_cycles++;
        end
    end

endmodule

/* bench/tb_fetch.sv */
`timescale 1ns/1ps

// Bench top: clock, reset, random redirects and credit returns for both harts
module tb_fetch;
    import fetch_pkg::*;

    // Traffic length, credit hold length and drain limit in cycles
    localparam int RUN_CYCLES  = 3000;
    localparam int HOLD_CYCLES = 40;
    localparam int DRAIN_LIMIT = 200;

    logic clk;
    logic rst_n;

    // Stimulus, one entry per hart
    logic redir_valid [NUM_HARTS];
    pc_t  redir_pc    [NUM_HARTS];
    logic credit_ret  [NUM_HARTS];

    // DUT outputs
    logic   instr_valid_h0;
    instr_t instr_h0;
    pc_t    instr_pc_h0;
    logic   instr_valid_h1;
    instr_t instr_h1;
    pc_t    instr_pc_h1;

    // Decoder side bookkeeping, delivered minus returned is what is owed
    int delivered  [NUM_HARTS] = '{0, 0};
    int returned   [NUM_HARTS];
    int ret_wait   [NUM_HARTS];
    int redir_wait [NUM_HARTS];

    // Phase flags
    logic hold;
    logic redirects_on;
    logic drain;
    int   bench_errs;
    int   total_errs;

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    fetch_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .redirect_valid_h0 (redir_valid[0]),
        .redirect_pc_h0    (redir_pc[0]),
        .credit_return_h0  (credit_ret[0]),
        .instr_valid_h0    (instr_valid_h0),
        .instr_h0          (instr_h0),
        .instr_pc_h0       (instr_pc_h0),
        .redirect_valid_h1 (redir_valid[1]),
        .redirect_pc_h1    (redir_pc[1]),
        .credit_return_h1  (credit_ret[1]),
        .instr_valid_h1    (instr_valid_h1),
        .instr_h1          (instr_h1),
        .instr_pc_h1       (instr_pc_h1)
    );

    tb_checker chk0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .hold_credits      (hold),
        .redirect_valid_h0 (redir_valid[0]),
        .redirect_pc_h0    (redir_pc[0]),
        .credit_return_h0  (credit_ret[0]),
        .instr_valid_h0    (instr_valid_h0),
        .instr_h0          (instr_h0),
        .instr_pc_h0       (instr_pc_h0),
        .redirect_valid_h1 (redir_valid[1]),
        .redirect_pc_h1    (redir_pc[1]),
        .credit_return_h1  (credit_ret[1]),
        .instr_valid_h1    (instr_valid_h1),
        .instr_h1          (instr_h1),
        .instr_pc_h1       (instr_pc_h1)
    );

    // Each delivery owes one credit back, new ones stop counting once draining
    always @(posedge clk) begin
        if (rst_n && !drain) begin
            if (instr_valid_h0) begin
                delivered[0] <= delivered[0] + 1;
            end
            if (instr_valid_h1) begin
                delivered[1] <= delivered[1] + 1;
            end
        end
    end

    // Called right after a falling edge
    task automatic drive_inputs();
        for (int h = 0; h < NUM_HARTS; h++) begin
            redir_valid[h] = 1'b0;
            credit_ret[h]  = 1'b0;
            if (redirects_on) begin
                if (redir_wait[h] == 0) begin
                    redir_valid[h] = 1'b1;
                    redir_pc[h]    = pc_t'($urandom);
                    redir_wait[h]  = $urandom_range(47, 8);
                end else begin
                    redir_wait[h]--;
                end
            end
            // one pulse per owed credit, random gap
            if (!hold && delivered[h] > returned[h]) begin
                if (ret_wait[h] == 0) begin
                    credit_ret[h] = 1'b1;
                    returned[h]++;
                    ret_wait[h]   = $urandom_range(5, 0);
                end else begin
                    ret_wait[h]--;
                end
            end
        end
    endtask

    initial begin : main
        int waited;
        void'($urandom(92125));
        rst_n        = 1'b0;
        hold         = 1'b0;
        redirects_on = 1'b0;
        drain        = 1'b0;
        bench_errs   = 0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            redir_valid[h] = 1'b0;
            redir_pc[h]    = RESET_PC;
            credit_ret[h]  = 1'b0;
            returned[h]    = 0;
            ret_wait[h]    = 0;
            redir_wait[h]  = $urandom_range(47, 8);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Credits withheld right after reset and twice mid-run
        for (int c = 0; c < RUN_CYCLES + HOLD_CYCLES; c++) begin
            @(negedge clk);
            hold = (c < HOLD_CYCLES)
                || (c >= 1000 && c < 1000 + HOLD_CYCLES)
                || (c >= 2000 && c < 2000 + HOLD_CYCLES);
            redirects_on = (c >= HOLD_CYCLES);
            drive_inputs();
        end

        // Drain: return what is owed, nothing new is owed
        @(negedge clk);
        hold         = 1'b0;
        redirects_on = 1'b0;
        drain        = 1'b1;
        drive_inputs();
        waited = 0;
        while ((delivered[0] > returned[0] || delivered[1] > returned[1])
               && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            drive_inputs();
            waited++;
        end
        if (delivered[0] > returned[0] || delivered[1] > returned[1]) begin
            bench_errs++;
            $display("timeout: owed credits were not all returned within %0d cycles",
                     DRAIN_LIMIT);
        end
        // Let the checker see the last return
        repeat (4) begin
            @(negedge clk);
            drive_inputs();
        end

        total_errs = chk0.content_errs + chk0.sequence_errs + chk0.redirect_errs
                   + chk0.credit_errs + chk0.progress_errs + chk0.reset_errs + bench_errs;
        $display("errors: content %0d, sequence %0d, redirect %0d, credit %0d, %s%0d, %s%0d, %s%0d",
                 chk0.content_errs, chk0.sequence_errs, chk0.redirect_errs, chk0.credit_errs,
                 "progress ", chk0.progress_errs, "reset ", chk0.reset_errs,
                 "bench ", bench_errs);
        if (total_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* fetch_sub.f */
source/fetch_pkg.sv
source/instr_rom.sv
source/rom_arbiter.sv
source/fetch_queue.sv
source/fetch_unit.sv
source/fetch_top.sv
bench/tb_checker.sv
bench/tb_fetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch subsystem testbench under Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_fetch \
    -Mdir obj_dir \
    -f fetch_sub.f

./obj_dir/Vtb_fetch | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

/* program.hex */
// One 32-bit RV32 instruction word per line, in hex
// Line n holds ROM word n, byte address n*4
00100093
00200113
002081b3
40208233
0030f2b3
0030e333
0030c3b3
00209433
0020d4b3
4020d533
0020a5b3
0020b633
00a00693
fff68693
fe069ee3
00c00713
00171793
0017d813
12345837
00001897
008000ef
00000013
00008067
00f70933
412709b3
00e7ca33
00e7eab3
00e7fb33
016a8bb3
017b0c33
00100073
0000006f
